// File: verilog/iq_pkg.sv
`default_nettype none

package iq_pkg;

    // ------------------------------------------------------------------
    // widths and sizes
    // ------------------------------------------------------------------
    localparam int WORD_W    = 32;
    localparam int TAG_W     = 6;
    localparam int IQ_SIZE   = 4;
    localparam int AGE_W     = 3;
    localparam int CDB_COUNT = 2;
    localparam int SRC_COUNT = 2;

    // index of one queue slot
    localparam int IQ_IDX_W  = $clog2(IQ_SIZE);

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [AGE_W-1:0]  age_t;

    // shifts take the low 5 bits of operand 1, SLT is signed
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5,
        SRL = 3'd6,
        SLT = 3'd7
    } alu_op_e;

    // ------------------------------------------------------------------
    // bundles
    // ------------------------------------------------------------------
    typedef struct packed {
        logic  present;
        tag_t  tag;
        word_t data;
    } operand_t;

    typedef struct packed {
        alu_op_e                     op;
        tag_t                        dst;
        operand_t [SRC_COUNT-1:0]    src;
    } dispatch_t;

    // one CDB channel or the self broadcast
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t data;
    } bcast_t;

    typedef struct packed {
        alu_op_e                  op;
        tag_t                     dst;
        word_t [SRC_COUNT-1:0]    data;
    } issue_t;

    typedef struct packed {
        tag_t  tag;
        word_t data;
    } result_t;

endpackage

`default_nettype wire

// File: verilog/iq_alloc.sv
`timescale 1ns/1ns
`default_nettype none

module iq_alloc (
    input  wire logic                        clk,
    input  wire logic                        arst_n_i,
    input  wire logic                        flush_i,
    input  wire logic                        dispatch_valid_i,
    input  wire logic [iq_pkg::IQ_SIZE-1:0]  entry_busy_i,
    output logic                             dispatch_ready_o,
    output logic      [iq_pkg::IQ_SIZE-1:0]  entry_write_o
);
    import iq_pkg::*;

    logic                accept;
    logic                found;
    logic [IQ_SIZE-1:0]  busy_next;
    logic                free_q;

    assign accept = dispatch_valid_i & dispatch_ready_o;

    // lowest index free slot takes the dispatch
    always_comb begin
        entry_write_o = '0;
        found         = 1'b0;
        for (int i = 0; i < IQ_SIZE; i++) begin
            if (!entry_busy_i[i] && !found) begin
                entry_write_o[i] = accept;
                found            = 1'b1;
            end
        end
    end

    // grants only free slots, so counting writes alone never overstates room
    assign busy_next = entry_busy_i | entry_write_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            free_q <= 1'b1;
        end else if (flush_i) begin
            free_q <= 1'b1;
        end else begin
            free_q <= ~&busy_next;
        end
    end

    assign dispatch_ready_o = free_q;

endmodule

`default_nettype wire

// File: verilog/iq_entry.sv
`timescale 1ns/1ns
`default_nettype none

module iq_entry (
    input  wire logic                                    clk,
    input  wire logic                                    arst_n_i,
    input  wire logic                                    flush_i,
    input  wire logic                                    write_i,
    input  wire logic                                    grant_i,
    input  wire iq_pkg::dispatch_t                       dispatch_i,
    input  wire iq_pkg::bcast_t [iq_pkg::CDB_COUNT:0]    bcast_i,
    output logic                                         busy_o,
    output logic                                         ready_o,
    output iq_pkg::issue_t                               issue_o
);
    import iq_pkg::*;

    logic                         busy_q;
    alu_op_e                      op_q;
    tag_t                         dst_q;
    operand_t [SRC_COUNT-1:0]     src_q;
    operand_t [SRC_COUNT-1:0]     src_base;
    operand_t [SRC_COUNT-1:0]     src_next;
    logic     [SRC_COUNT-1:0]     src_present;

    // ------------------------------------------------------------------
    // operand snoop
    // ------------------------------------------------------------------
    // a fresh dispatch is snooped too, so a same cycle broadcast is not lost
    always_comb begin
        src_base = write_i ? dispatch_i.src : src_q;
        src_next = src_base;
        for (int s = 0; s < SRC_COUNT; s++) begin
            for (int b = 0; b <= CDB_COUNT; b++) begin
                if (!src_base[s].present && bcast_i[b].valid &&
                    bcast_i[b].tag == src_base[s].tag) begin
                    src_next[s].present = 1'b1;
                    src_next[s].data    = bcast_i[b].data;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        src_q <= src_next;
        if (write_i) begin
            op_q  <= dispatch_i.op;
            dst_q <= dispatch_i.dst;
        end
    end

    // ------------------------------------------------------------------
    // occupancy
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= 1'b0;
        end else if (flush_i) begin
            busy_q <= 1'b0;
        end else if (write_i) begin
            busy_q <= 1'b1;
        end else if (grant_i) begin
            busy_q <= 1'b0;
        end
    end

    always_comb begin
        for (int s = 0; s < SRC_COUNT; s++) begin
            src_present[s] = src_q[s].present;
        end
    end

    assign busy_o  = busy_q;
    assign ready_o = busy_q & (&src_present);

    always_comb begin
        issue_o.op  = op_q;
        issue_o.dst = dst_q;
        for (int s = 0; s < SRC_COUNT; s++) begin
            issue_o.data[s] = src_q[s].data;
        end
    end

endmodule

`default_nettype wire

// File: verilog/iq_age_select.sv
`timescale 1ns/1ns
`default_nettype none

module iq_age_select (
    input  wire logic                        clk,
    input  wire logic                        arst_n_i,
    input  wire logic                        flush_i,
    input  wire logic                        advance_i,
    input  wire logic [iq_pkg::IQ_SIZE-1:0]  entry_write_i,
    input  wire logic [iq_pkg::IQ_SIZE-1:0]  entry_ready_i,
    output logic      [iq_pkg::IQ_SIZE-1:0]  grant_o
);
    import iq_pkg::*;

    localparam int NODES = 2 * IQ_SIZE - 1;

    age_t [IQ_SIZE-1:0]                    age_q;
    logic [NODES-1:0][AGE_W:0]             node_key;
    logic [NODES-1:0][IQ_IDX_W-1:0]        node_idx;
    logic [IQ_IDX_W-1:0]                   win_idx;

    // ------------------------------------------------------------------
    // age counters, cleared on write, saturating at the top
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            age_q <= '0;
        end else if (flush_i) begin
            age_q <= '0;
        end else begin
            for (int i = 0; i < IQ_SIZE; i++) begin
                if (entry_write_i[i]) begin
                    age_q[i] <= '0;
                end else if (age_q[i] != '1) begin
                    age_q[i] <= age_q[i] + 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // comparison tree
    // ------------------------------------------------------------------
    // heap layout, leaves in index order; key is ready bit above age
    always_comb begin
        node_key = '0;
        node_idx = '0;
        for (int i = 0; i < IQ_SIZE; i++) begin
            node_key[IQ_SIZE-1+i] = {entry_ready_i[i], age_q[i]};
            node_idx[IQ_SIZE-1+i] = IQ_IDX_W'(i);
        end
        for (int n = IQ_SIZE - 2; n >= 0; n--) begin
            // strict compare, so a tie keeps the left (lower) index
            if (node_key[2*n+2] > node_key[2*n+1]) begin
                node_key[n] = node_key[2*n+2];
                node_idx[n] = node_idx[2*n+2];
            end else begin
                node_key[n] = node_key[2*n+1];
                node_idx[n] = node_idx[2*n+1];
            end
        end
    end

    assign win_idx = node_idx[0];

    always_comb begin
        grant_o          = '0;
        grant_o[win_idx] = node_key[0][AGE_W] & advance_i;
    end

endmodule

`default_nettype wire

// File: verilog/alu_exec.sv
`timescale 1ns/1ns
`default_nettype none

module alu_exec (
    input  wire logic              clk,
    input  wire logic              arst_n_i,
    input  wire logic              flush_i,
    input  wire logic              issue_valid_i,
    input  wire iq_pkg::issue_t    issue_i,
    input  wire logic              result_fifo_ready_i,
    output logic                   advance_o,
    output iq_pkg::bcast_t         self_bcast_o,
    output logic                   result_valid_o,
    output iq_pkg::result_t        result_o
);
    import iq_pkg::*;

    logic     opr_valid_q;
    issue_t   opr_q;
    logic     res_valid_q;
    result_t  res_q;
    word_t    src0;
    word_t    src1;
    word_t    alu_out;

    // result slot empty or leaving this cycle
    assign advance_o = ~res_valid_q | result_fifo_ready_i;

    // ------------------------------------------------------------------
    // pipeline valid bits
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            opr_valid_q <= 1'b0;
            res_valid_q <= 1'b0;
        end else if (flush_i) begin
            opr_valid_q <= 1'b0;
            res_valid_q <= 1'b0;
        end else if (advance_o) begin
            opr_valid_q <= issue_valid_i;
            res_valid_q <= opr_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_o) begin
            opr_q    <= issue_i;
            res_q    <= '{tag: opr_q.dst, data: alu_out};
        end
    end

    // ------------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------------
    assign src0 = opr_q.data[0];
    assign src1 = opr_q.data[1];

    always_comb begin
        case (opr_q.op)
            ADD:     alu_out = src0 + src1;
            SUB:     alu_out = src0 - src1;
            AND:     alu_out = src0 & src1;
            OR:      alu_out = src0 | src1;
            XOR:     alu_out = src0 ^ src1;
            SLL:     alu_out = src0 << src1[4:0];
            SRL:     alu_out = src0 >> src1[4:0];
            SLT:     alu_out = ($signed(src0) < $signed(src1)) ? 1 : 0;
            default: alu_out = '0;
        endcase
    end

    // wakes dependents in the cycle the result register loads
    always_comb begin
        self_bcast_o.valid = opr_valid_q & advance_o;
        self_bcast_o.tag   = opr_q.dst;
        self_bcast_o.data  = alu_out;
    end

    assign result_valid_o = res_valid_q;
    assign result_o       = res_q;

endmodule

`default_nettype wire

// File: verilog/alu_iq.sv
`timescale 1ns/1ns
`default_nettype none

module alu_iq (
    input  wire logic                                    clk,
    input  wire logic                                    arst_n_i,
    input  wire logic                                    flush_i,
    input  wire logic                                    dispatch_valid_i,
    input  wire iq_pkg::dispatch_t                       dispatch_i,
    output logic                                         dispatch_ready_o,
    input  wire iq_pkg::bcast_t [iq_pkg::CDB_COUNT-1:0]  cdb_i,
    input  wire logic                                    result_fifo_ready_i,
    output logic                                         result_valid_o,
    output iq_pkg::result_t                              result_o
);
    import iq_pkg::*;

    logic   [IQ_SIZE-1:0]    entry_busy;
    logic   [IQ_SIZE-1:0]    entry_ready;
    logic   [IQ_SIZE-1:0]    entry_write;
    logic   [IQ_SIZE-1:0]    grant;
    issue_t [IQ_SIZE-1:0]    entry_issue;
    issue_t                  issue_sel;
    logic                    advance;
    bcast_t                  self_bcast;
    bcast_t [CDB_COUNT:0]    bcast_bus;

    // self broadcast sits on the top channel
    assign bcast_bus = {self_bcast, cdb_i};

    // ------------------------------------------------------------------
    // allocation
    // ------------------------------------------------------------------
    iq_alloc u_alloc (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .flush_i          (flush_i),
        .dispatch_valid_i (dispatch_valid_i),
        .entry_busy_i     (entry_busy),
        .dispatch_ready_o (dispatch_ready_o),
        .entry_write_o    (entry_write)
    );

    // ------------------------------------------------------------------
    // queue slots
    // ------------------------------------------------------------------
    for (genvar i = 0; i < IQ_SIZE; i++) begin : gen_entry
        iq_entry u_entry (
            .clk        (clk),
            .arst_n_i   (arst_n_i),
            .flush_i    (flush_i),
            .write_i    (entry_write[i]),
            .grant_i    (grant[i]),
            .dispatch_i (dispatch_i),
            .bcast_i    (bcast_bus),
            .busy_o     (entry_busy[i]),
            .ready_o    (entry_ready[i]),
            .issue_o    (entry_issue[i])
        );
    end

    iq_age_select u_age_select (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .flush_i       (flush_i),
        .advance_i     (advance),
        .entry_write_i (entry_write),
        .entry_ready_i (entry_ready),
        .grant_o       (grant)
    );

    // grant is one-hot, so OR-ing the masked slots is the mux
    always_comb begin
        issue_sel = '0;
        for (int i = 0; i < IQ_SIZE; i++) begin
            issue_sel = issue_sel | (entry_issue[i] & {$bits(issue_t){grant[i]}});
        end
    end

    // ------------------------------------------------------------------
    // execute
    // ------------------------------------------------------------------
    alu_exec u_exec (
        .clk                 (clk),
        .arst_n_i            (arst_n_i),
        .flush_i             (flush_i),
        .issue_valid_i       (|grant),
        .issue_i             (issue_sel),
        .result_fifo_ready_i (result_fifo_ready_i),
        .advance_o           (advance),
        .self_bcast_o        (self_bcast),
        .result_valid_o      (result_valid_o),
        .result_o            (result_o)
    );

endmodule

`default_nettype wire

// File: verification/alu_iq_assert.sv
`timescale 1ns/1ns
`default_nettype none

module alu_iq_assert (
    input wire logic             clk,
    input wire logic             arst_n_i,
    input wire logic             flush_i,
    input wire logic             dispatch_ready_o,
    input wire logic             result_fifo_ready_i,
    input wire logic             result_valid_o,
    input wire iq_pkg::result_t  result_o
);

    // stalled result holds until the FIFO takes it
    result_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        (result_valid_o && !result_fifo_ready_i && !flush_i) |=>
            (result_valid_o && $stable(result_o)))
        else $error("result changed while the downstream FIFO stalled");

    flush_drops_result: assert property (@(posedge clk) disable iff (!arst_n_i)
        flush_i |=> !result_valid_o)
        else $error("result valid in the cycle after a flush");

    flush_frees_queue: assert property (@(posedge clk) disable iff (!arst_n_i)
        flush_i |=> dispatch_ready_o)
        else $error("dispatch not ready in the cycle after a flush");

endmodule

bind alu_iq alu_iq_assert u_assert (
    .clk                 (clk),
    .arst_n_i            (arst_n_i),
    .flush_i             (flush_i),
    .dispatch_ready_o    (dispatch_ready_o),
    .result_fifo_ready_i (result_fifo_ready_i),
    .result_valid_o      (result_valid_o),
    .result_o            (result_o)
);

`default_nettype wire

// File: verification/alu_iq_tb.sv
`timescale 1ns/1ns
`default_nettype none

module alu_iq_tb;
    import iq_pkg::*;

    localparam int NTAGS  = 1 << TAG_W;
    localparam int CYCLES = 3000;

    logic                    clk;
    logic                    arst_n_i;
    logic                    flush_i;
    logic                    dispatch_valid_i;
    dispatch_t               dispatch_i;
    logic                    dispatch_ready_o;
    bcast_t [CDB_COUNT-1:0]  cdb_i;
    logic                    result_fifo_ready_i;
    logic                    result_valid_o;
    result_t                 result_o;

    integer seed = 13431;

    // reference model, indexed by tag
    logic                      tag_busy [NTAGS];
    logic                      live     [NTAGS];
    logic                      seen     [NTAGS];
    logic                      ext_wait [NTAGS];
    alu_op_e                   op_m     [NTAGS];
    operand_t [SRC_COUNT-1:0]  src_m    [NTAGS];
    int                        outstanding;
    int                        ext_count;
    int                        next_tag;
    logic                      hold;
    result_t                   hold_res;
    logic                      flushed;

    alu_iq DUT (
        .clk                 (clk),
        .arst_n_i            (arst_n_i),
        .flush_i             (flush_i),
        .dispatch_valid_i    (dispatch_valid_i),
        .dispatch_i          (dispatch_i),
        .dispatch_ready_o    (dispatch_ready_o),
        .cdb_i               (cdb_i),
        .result_fifo_ready_i (result_fifo_ready_i),
        .result_valid_o      (result_valid_o),
        .result_o            (result_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // ------------------------------------------------------------------
    // model helpers
    // ------------------------------------------------------------------
    function automatic word_t model_alu(alu_op_e op, word_t a, word_t b);
        case (op)
            ADD:     return a + b;
            SUB:     return a + ~b + 1'b1;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            // signed less-than, sign bits decide when they differ
            default: return (a[WORD_W-1] != b[WORD_W-1]) ? word_t'(a[WORD_W-1]) : word_t'(a < b);
        endcase
    endfunction

    // round robin, so a tag killed by flush is not reused soon
    function automatic tag_t alloc_tag();
        tag_t t;
        for (int i = 0; i < NTAGS; i++) begin
            t = tag_t'(next_tag + i);
            if (!tag_busy[t]) begin
                tag_busy[t] = 1'b1;
                next_tag    = t + 1;
                return t;
            end
        end
        return '0;
    endfunction

    // external: a tag still to be broadcast; else a producer not yet broadcast
    function automatic int pick_tag(input bit external);
        int base;
        int t;
        base = (($random(seed)) & (NTAGS - 1));
        for (int i = 0; i < NTAGS; i++) begin
            t = (base + i) % NTAGS;
            if (external ? ext_wait[t] : (live[t] && !seen[t])) begin
                return t;
            end
        end
        return -1;
    endfunction

    task automatic resolve(input tag_t tag, input word_t val);
        for (int t = 0; t < NTAGS; t++) begin
            for (int s = 0; s < SRC_COUNT; s++) begin
                if (live[t] && !src_m[t][s].present && src_m[t][s].tag == tag) begin
                    src_m[t][s].present = 1'b1;
                    src_m[t][s].data    = val;
                end
            end
        end
    endtask

    task automatic take_result(input result_t r);
        word_t exp;
        assert (live[r.tag]) else abort_run($sformatf("result with unexpected tag %0d", r.tag));
        assert (src_m[r.tag][0].present && src_m[r.tag][1].present)
        else abort_run($sformatf("tag %0d completed before its CDB operand was sent", r.tag));
        exp = model_alu(op_m[r.tag], src_m[r.tag][0].data, src_m[r.tag][1].data);
        assert (r.data === exp)
        else abort_run($sformatf("CHECK FAILED: result tag %0d op %s expected %h actual %h",
                                 r.tag, op_m[r.tag].name(), exp, r.data));
        live[r.tag]     = 1'b0;
        tag_busy[r.tag] = 1'b0;
        outstanding--;
        resolve(r.tag, exp);
    endtask

    task automatic make_dispatch();
        dispatch_t d;
        int        kind;
        int        t;
        d.op  = alu_op_e'(3'($random(seed)));
        d.dst = alloc_tag();
        for (int s = 0; s < SRC_COUNT; s++) begin
            kind = ($random(seed)) & 7;
            t    = -1;
            if (kind == 5) begin
                t = pick_tag(1'b0);
            end else if (kind == 6 && ext_count < 3) begin
                t = alloc_tag();
                ext_wait[t] = 1'b1;
                ext_count++;
            end else if (kind == 7) begin
                t = pick_tag(1'b1);
            end
            d.src[s].present = (t < 0);
            d.src[s].tag     = (t < 0) ? tag_t'($random(seed)) : tag_t'(t);
            d.src[s].data    = $random(seed);
        end
        live[d.dst]      = 1'b1;
        seen[d.dst]      = 1'b0;
        op_m[d.dst]      = d.op;
        src_m[d.dst]     = d.src;
        outstanding++;
        dispatch_valid_i = 1'b1;
        dispatch_i       = d;
    endtask

    task automatic drive_cdb(input int pct);
        int t;
        for (int c = 0; c < CDB_COUNT; c++) begin
            t = pick_tag(1'b1);
            if (t >= 0 && (($random(seed)) & 127) < pct) begin
                cdb_i[c] = '{valid: 1'b1, tag: tag_t'(t), data: $random(seed)};
                ext_wait[t] = 1'b0;
                tag_busy[t] = 1'b0;
                ext_count--;
                resolve(tag_t'(t), cdb_i[c].data);
            end
        end
    endtask

    task automatic clear_model();
        for (int t = 0; t < NTAGS; t++) begin
            tag_busy[t] = 1'b0;
            live[t]     = 1'b0;
            seen[t]     = 1'b0;
            ext_wait[t] = 1'b0;
        end
        outstanding = 0;
        ext_count   = 0;
    endtask

    // ------------------------------------------------------------------
    // one clock cycle: check outputs, then drive the next inputs
    // ------------------------------------------------------------------
    task automatic run_cycle(input bit allow_dispatch, input bit allow_flush);
        @(negedge clk);
        if (flushed) begin
            assert (!result_valid_o && dispatch_ready_o)
            else abort_run("queue not empty in the cycle after a flush");
        end
        if (hold) begin
            assert (result_valid_o && result_o === hold_res)
            else abort_run("result changed or dropped while the FIFO was not ready");
        end
        if (result_valid_o) begin
            seen[result_o.tag] = 1'b1;
        end
        if (outstanding >= IQ_SIZE + 2) begin
            assert (!dispatch_ready_o) else abort_run("dispatch ready with every entry occupied");
        end
        flushed             = allow_flush && ((($random(seed)) & 255) == 0);
        flush_i             = flushed;
        dispatch_valid_i    = 1'b0;
        cdb_i               = '0;
        result_fifo_ready_i = 1'b0;
        if (flushed) begin
            clear_model();
        end else begin
            result_fifo_ready_i = !allow_dispatch || ((($random(seed)) & 3) != 0);
            if (result_valid_o && result_fifo_ready_i) begin
                take_result(result_o);
            end
            if (allow_dispatch && dispatch_ready_o && (($random(seed)) & 1)) begin
                make_dispatch();
            end
            drive_cdb(allow_dispatch ? 40 : 128);
        end
        hold     = result_valid_o && !result_fifo_ready_i && !flushed;
        hold_res = result_o;
    endtask

    initial begin
        arst_n_i            = 1'b0;
        flush_i             = 1'b0;
        dispatch_valid_i    = 1'b0;
        dispatch_i          = '0;
        cdb_i               = '0;
        result_fifo_ready_i = 1'b0;
        clear_model();
        next_tag = 0;
        hold     = 1'b0;
        flushed  = 1'b0;
        repeat (2) @(negedge clk);
        arst_n_i = 1'b1;
        for (int i = 0; i < CYCLES; i++) begin
            run_cycle(1'b1, i > 20);
        end
        // drain, with its own timeout
        for (int i = 0; i < 500 && (outstanding > 0 || ext_count > 0); i++) begin
            run_cycle(1'b0, 1'b0);
        end
        assert (outstanding == 0) else abort_run("results still missing after the drain timeout");
        // late or repeated results would show up here
        repeat (8) run_cycle(1'b0, 1'b0);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
verilog/iq_pkg.sv
verilog/iq_alloc.sv
verilog/iq_entry.sv
verilog/iq_age_select.sv
verilog/alu_exec.sv
verilog/alu_iq.sv
verification/alu_iq_assert.sv
verification/alu_iq_tb.sv

// File: Bender.yml
package:
  name: alu_iq

sources:
  - files:
      - verilog/iq_pkg.sv
      - verilog/iq_alloc.sv
      - verilog/iq_entry.sv
      - verilog/iq_age_select.sv
      - verilog/alu_exec.sv
      - verilog/alu_iq.sv
  - target: simulation
    files:
      - verification/alu_iq_assert.sv
      - verification/alu_iq_tb.sv
